// ==== include/frontend_cfg.svh ====
// front end configuration: datapath widths, credit depth and register map
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

//////////////////////////////
// datapath
//////////////////////////////

// address and data width of the core
`define FE_XLEN 32
// one fetch block holds two instructions
`define FE_FETCH_W 64

//////////////////////////////
// flow control and registers
//////////////////////////////

// downstream slots, must be 2 or more
`define FE_CREDIT_MAX 4

`define FE_CFG_BOOT 2'd0
`define FE_CFG_CTRL 2'd1
`define FE_CFG_COUNT 2'd2

`endif

// ==== verilog/frontend_pkg.sv ====
// shared types of the dual issue front end: opcode and ALU enums, packet and redirect structs
`include "frontend_cfg.svh"

package frontend_pkg;

	//////////////////////////////
	// decode enums
	//////////////////////////////

	// major class, from bits 6..0 of the instruction
	typedef enum logic [3:0] {
		OP      = 4'd0,
		OP_IMM  = 4'd1,
		LOAD    = 4'd2,
		STORE   = 4'd3,
		BRANCH  = 4'd4,
		JAL     = 4'd5,
		JALR    = 4'd6,
		LUI     = 4'd7,
		AUIPC   = 4'd8,
		SYSTEM  = 4'd9,
		ILLEGAL = 4'd10
	} opcode_class_e;

	// ALU operation, ADD for anything that is not OP or OP_IMM
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		SLL  = 4'd2,
		SLT  = 4'd3,
		SLTU = 4'd4,
		XOR  = 4'd5,
		SRL  = 4'd6,
		SRA  = 4'd7,
		OR   = 4'd8,
		AND  = 4'd9
	} alu_func_e;

	//////////////////////////////
	// pipeline structs
	//////////////////////////////

	// one decoded instruction on its way to rename
	typedef struct packed {
		logic                valid;
		logic [`FE_XLEN-1:0] pc;
		logic [31:0]         inst;
		opcode_class_e       opcode_class;
		alu_func_e           alu_func;
		logic [4:0]          dest_reg;
		logic [4:0]          src1_reg;
		logic [4:0]          src2_reg;
		logic                src1_needed;
		logic                src2_needed;
		logic                illegal;
	} dispatch_packet_t;

	// pc steering request, squash from the ROB or a restart
	typedef struct packed {
		logic                valid;
		logic [`FE_XLEN-1:0] target;
	} redirect_t;

endpackage

// ==== verilog/inst_decoder.sv ====
// RV32I decoder that turns one instruction word into dispatch packet fields
module inst_decoder (
	input  logic [31:0]                 inst,
	output frontend_pkg::opcode_class_e opcode_class,
	output frontend_pkg::alu_func_e     alu_func,
	output logic [4:0]                  dest_reg,
	output logic [4:0]                  src1_reg,
	output logic [4:0]                  src2_reg,
	output logic                        src1_needed,
	output logic                        src2_needed,
	output logic                        illegal
);
	import frontend_pkg::*;

	// base opcodes of RV32I
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_alt;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic       writes_rd;

	assign opcode     = inst[6:0];
	assign rd         = inst[11:7];
	assign funct3     = inst[14:12];
	assign rs1        = inst[19:15];
	assign rs2        = inst[24:20];
	// bit 30 picks SUB and SRA
	assign funct7_alt = inst[30];

	//////////////////////////////
	// opcode class
	//////////////////////////////

	always_comb begin
		if (opcode[1:0] != 2'b11) begin
			// 16-bit encodings are not supported
			opcode_class = ILLEGAL;
		end else begin
			case (opcode)
				OPC_OP:     opcode_class = OP;
				OPC_OP_IMM: opcode_class = OP_IMM;
				OPC_LOAD:   opcode_class = LOAD;
				OPC_STORE:  opcode_class = STORE;
				OPC_BRANCH: opcode_class = BRANCH;
				OPC_JAL:    opcode_class = JAL;
				OPC_JALR:   opcode_class = JALR;
				OPC_LUI:    opcode_class = LUI;
				OPC_AUIPC:  opcode_class = AUIPC;
				OPC_SYSTEM: opcode_class = SYSTEM;
				default:    opcode_class = ILLEGAL;
			endcase
		end
	end

	assign illegal = (opcode_class == ILLEGAL);

	//////////////////////////////
	// ALU function
	//////////////////////////////

	always_comb begin
		alu_func = ADD;
		if (opcode_class == OP || opcode_class == OP_IMM) begin
			case (funct3)
				// immediate forms have no subtract
				3'b000:  alu_func = (opcode_class == OP && funct7_alt) ? SUB : ADD;
				3'b001:  alu_func = SLL;
				3'b010:  alu_func = SLT;
				3'b011:  alu_func = SLTU;
				3'b100:  alu_func = XOR;
				3'b101:  alu_func = funct7_alt ? SRA : SRL;
				3'b110:  alu_func = OR;
				default: alu_func = AND;
			endcase
		end
	end

	//////////////////////////////
	// register usage
	//////////////////////////////

	// SYSTEM is only recognized here, it produces no result
	always_comb begin
		case (opcode_class)
			OP, OP_IMM, LOAD, JAL, JALR, LUI, AUIPC: writes_rd = 1'b1;
			default:                                 writes_rd = 1'b0;
		endcase
	end

	always_comb begin
		case (opcode_class)
			LUI, AUIPC, JAL: src1_needed = 1'b0;
			default:         src1_needed = 1'b1;
		endcase
	end

	always_comb begin
		case (opcode_class)
			OP, STORE, BRANCH: src2_needed = 1'b1;
			default:           src2_needed = 1'b0;
		endcase
	end

	// unused indices go out as x0 so rename sees no false dependency
	assign dest_reg = writes_rd ? rd : 5'd0;
	assign src1_reg = src1_needed ? rs1 : 5'd0;
	assign src2_reg = src2_needed ? rs2 : 5'd0;

endmodule

// ==== verilog/fetch_dispatch.sv ====
// fetch and dispatch unit holding the program counter, word selection, credit count and packets
`include "frontend_cfg.svh"

module fetch_dispatch (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           fetch_enable,
	input  frontend_pkg::redirect_t        restart,
	input  frontend_pkg::redirect_t        redirect,
	input  logic [1:0]                     credit_return,
	output logic [`FE_XLEN-1:0]            imem_addr,
	input  logic [`FE_FETCH_W-1:0]         imem_data,
	input  logic                           imem_valid,
	output frontend_pkg::dispatch_packet_t dispatch_0,
	output frontend_pkg::dispatch_packet_t dispatch_1,
	output logic [1:0]                     dispatch_count_inc
);
	import frontend_pkg::*;

	localparam int CREDIT_W = $clog2(`FE_CREDIT_MAX + 1);
	localparam int SUM_W    = CREDIT_W + 1;
	localparam logic [CREDIT_W-1:0] CREDIT_FULL = CREDIT_W'(`FE_CREDIT_MAX);

	logic [`FE_XLEN-1:0]  pc;
	logic [`FE_XLEN-1:0]  pc_plus_4;
	logic [`FE_XLEN-1:0]  pc_plus_8;
	logic [`FE_XLEN-1:0]  pc_next;
	logic [CREDIT_W-1:0]  credits;
	logic [SUM_W-1:0]     credits_sum;
	logic [CREDIT_W-1:0]  credits_next;
	logic [31:0]          word_0;
	logic [31:0]          word_1;
	logic                 squash;
	logic                 take_0;
	logic                 take_1;
	dispatch_packet_t     pkt_0;
	dispatch_packet_t     pkt_1;

	//////////////////////////////
	// fetch address and words
	//////////////////////////////

	assign imem_addr = {pc[`FE_XLEN-1:3], 3'b000};
	assign pc_plus_4 = pc + `FE_XLEN'(4);
	assign pc_plus_8 = pc + `FE_XLEN'(8);

	// unaligned pc starts in the upper half of the block
	assign word_0 = pc[2] ? imem_data[63:32] : imem_data[31:0];
	assign word_1 = imem_data[63:32];

	//////////////////////////////
	// slot selection
	//////////////////////////////

	assign squash = redirect.valid || restart.valid;
	assign take_0 = !squash && fetch_enable && imem_valid && (credits != '0);
	// second slot needs an aligned pc and a second credit
	assign take_1 = take_0 && !pc[2] && (credits >= CREDIT_W'(2));

	assign dispatch_count_inc = {take_1, take_0 && !take_1};

	// external squash wins over a restart from software
	always_comb begin
		if (redirect.valid) begin
			pc_next = redirect.target;
		end else if (restart.valid) begin
			pc_next = restart.target;
		end else if (take_1) begin
			pc_next = pc_plus_8;
		end else if (take_0) begin
			pc_next = pc_plus_4;
		end else begin
			pc_next = pc;
		end
	end

	// returns and consumptions land on the same edge
	assign credits_sum = {1'b0, credits} + SUM_W'(credit_return) - SUM_W'(dispatch_count_inc);
	assign credits_next = (credits_sum > SUM_W'(`FE_CREDIT_MAX)) ? CREDIT_FULL
	                                                             : credits_sum[CREDIT_W-1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			pc      <= '0;
			credits <= CREDIT_FULL;
		end else begin
			pc      <= pc_next;
			credits <= credits_next;
		end
	end

	//////////////////////////////
	// decode and packets
	//////////////////////////////

	inst_decoder u_decoder_0 (
		.inst         (word_0),
		.opcode_class (pkt_0.opcode_class),
		.alu_func     (pkt_0.alu_func),
		.dest_reg     (pkt_0.dest_reg),
		.src1_reg     (pkt_0.src1_reg),
		.src2_reg     (pkt_0.src2_reg),
		.src1_needed  (pkt_0.src1_needed),
		.src2_needed  (pkt_0.src2_needed),
		.illegal      (pkt_0.illegal)
	);

	inst_decoder u_decoder_1 (
		.inst         (word_1),
		.opcode_class (pkt_1.opcode_class),
		.alu_func     (pkt_1.alu_func),
		.dest_reg     (pkt_1.dest_reg),
		.src1_reg     (pkt_1.src1_reg),
		.src2_reg     (pkt_1.src2_reg),
		.src1_needed  (pkt_1.src1_needed),
		.src2_needed  (pkt_1.src2_needed),
		.illegal      (pkt_1.illegal)
	);

	assign pkt_0.valid = take_0;
	assign pkt_0.pc    = pc;
	assign pkt_0.inst  = word_0;
	assign pkt_1.valid = take_1;
	assign pkt_1.pc    = pc_plus_4;
	assign pkt_1.inst  = word_1;

	// packets reach rename one cycle after their fetch
	always_ff @(posedge clock) begin
		dispatch_0 <= pkt_0;
		dispatch_1 <= pkt_1;
		if (reset) begin
			dispatch_0.valid <= 1'b0;
			dispatch_1.valid <= 1'b0;
		end
	end

endmodule

// ==== verilog/frontend_csr.sv ====
// configuration block: boot address, fetch enable, restart pulse and dispatched instruction count
`include "frontend_cfg.svh"

module frontend_csr (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    cfg_write,
	input  logic [1:0]              cfg_addr,
	input  logic [`FE_XLEN-1:0]     cfg_wdata,
	output logic [`FE_XLEN-1:0]     cfg_rdata,
	input  logic [1:0]              dispatch_count_inc,
	output logic                    fetch_enable,
	output frontend_pkg::redirect_t restart
);
	logic [`FE_XLEN-1:0] boot_addr;
	logic [`FE_XLEN-1:0] dispatch_count;
	logic                restart_pending;
	logic                write_boot;
	logic                write_ctrl;
	logic                write_count;

	assign write_boot  = cfg_write && (cfg_addr == `FE_CFG_BOOT);
	assign write_ctrl  = cfg_write && (cfg_addr == `FE_CFG_CTRL);
	assign write_count = cfg_write && (cfg_addr == `FE_CFG_COUNT);

	//////////////////////////////
	// registers
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			boot_addr       <= '0;
			fetch_enable    <= 1'b0;
			restart_pending <= 1'b0;
			dispatch_count  <= '0;
		end else begin
			// one cycle pulse after every boot write
			restart_pending <= write_boot;
			if (write_boot) begin
				boot_addr <= cfg_wdata;
			end
			if (write_ctrl) begin
				fetch_enable <= cfg_wdata[0];
			end
			// clearing beats this cycle's increment
			if (write_count) begin
				dispatch_count <= '0;
			end else begin
				dispatch_count <= dispatch_count + `FE_XLEN'(dispatch_count_inc);
			end
		end
	end

	assign restart.valid  = restart_pending;
	assign restart.target = boot_addr;

	always_comb begin
		case (cfg_addr)
			`FE_CFG_BOOT:  cfg_rdata = boot_addr;
			`FE_CFG_CTRL:  cfg_rdata = {{(`FE_XLEN-1){1'b0}}, fetch_enable};
			`FE_CFG_COUNT: cfg_rdata = dispatch_count;
			default:       cfg_rdata = '0;
		endcase
	end

endmodule

// ==== verilog/frontend_top.sv ====
// front end top level joining the configuration block and the fetch/dispatch unit
`include "frontend_cfg.svh"

module frontend_top (
	input  logic                           clock,
	input  logic                           reset,
	output logic [`FE_XLEN-1:0]            imem_addr,
	input  logic [`FE_FETCH_W-1:0]         imem_data,
	input  logic                           imem_valid,
	input  frontend_pkg::redirect_t        redirect,
	input  logic [1:0]                     credit_return,
	output frontend_pkg::dispatch_packet_t dispatch_0,
	output frontend_pkg::dispatch_packet_t dispatch_1,
	input  logic                           cfg_write,
	input  logic [1:0]                     cfg_addr,
	input  logic [`FE_XLEN-1:0]            cfg_wdata,
	output logic [`FE_XLEN-1:0]            cfg_rdata
);
	import frontend_pkg::*;

	// control from the configuration block
	logic      fetch_enable;
	redirect_t restart;
	// per-cycle dispatch count back to the counter
	logic [1:0] dispatch_count_inc;

	frontend_csr u_frontend_csr (
		.clock              (clock),
		.reset              (reset),
		.cfg_write          (cfg_write),
		.cfg_addr           (cfg_addr),
		.cfg_wdata          (cfg_wdata),
		.cfg_rdata          (cfg_rdata),
		.dispatch_count_inc (dispatch_count_inc),
		.fetch_enable       (fetch_enable),
		.restart            (restart)
	);

	fetch_dispatch u_fetch_dispatch (
		.clock              (clock),
		.reset              (reset),
		.fetch_enable       (fetch_enable),
		.restart            (restart),
		.redirect           (redirect),
		.credit_return      (credit_return),
		.imem_addr          (imem_addr),
		.imem_data          (imem_data),
		.imem_valid         (imem_valid),
		.dispatch_0         (dispatch_0),
		.dispatch_1         (dispatch_1),
		.dispatch_count_inc (dispatch_count_inc)
	);

endmodule

// ==== testbench/frontend_tb.sv ====
// front end testbench driven by a trace file with memory and downstream credit models
`include "frontend_cfg.svh"

module frontend_tb;
	import frontend_pkg::*;

	localparam int MEM_WORDS  = 256;
	localparam int WAIT_LIMIT = 400;

	typedef struct packed {
		logic [31:0] pc;
		logic [3:0]  op_class;
		logic [4:0]  dest;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
	} expect_t;

	logic                   clock;
	logic                   reset;
	logic [`FE_XLEN-1:0]    imem_addr;
	logic [`FE_FETCH_W-1:0] imem_data;
	logic                   imem_valid;
	redirect_t              redirect;
	logic [1:0]             credit_return;
	dispatch_packet_t       dispatch_0;
	dispatch_packet_t       dispatch_1;
	logic                   cfg_write;
	logic [1:0]             cfg_addr;
	logic [`FE_XLEN-1:0]    cfg_wdata;
	logic [`FE_XLEN-1:0]    cfg_rdata;

	logic [31:0]  mem [MEM_WORDS];
	expect_t      expected_q [$];
	expect_t      entry;
	logic [31:0]  rnd_state;
	// block address of the fetch whose packets show up at the next sample
	logic [31:0]  fetch_addr;
	logic [31:0]  addr;
	logic [31:0]  word;
	logic [7:0]   kind;
	logic [1023:0] line_buf;
	int           fd;
	int           code;
	int           cls;
	int           dst;
	int           s1;
	int           s2;
	int           errors;
	int           seen_count;
	int           held;
	int           hold_left;
	int           quiet;
	bit           drain_ok;
	bit           stop_run;
	bit           done;

	frontend_top u_frontend_top (
		.clock         (clock),
		.reset         (reset),
		.imem_addr     (imem_addr),
		.imem_data     (imem_data),
		.imem_valid    (imem_valid),
		.redirect      (redirect),
		.credit_return (credit_return),
		.dispatch_0    (dispatch_0),
		.dispatch_1    (dispatch_1),
		.cfg_write     (cfg_write),
		.cfg_addr      (cfg_addr),
		.cfg_wdata     (cfg_wdata),
		.cfg_rdata     (cfg_rdata)
	);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	// instruction memory answers in the same cycle
	assign imem_data = {mem[{imem_addr[9:3], 1'b1}], mem[{imem_addr[9:3], 1'b0}]};

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		lcg_next = state * 32'd1664525 + 32'd1013904223;
	endfunction

	//////////////////////////////
	// checks
	//////////////////////////////

	task automatic report_value(input string name, input logic [31:0] want,
	                            input logic [31:0] got);
		errors++;
		$display("error at %0t: %s expected %h, actual %h", $time, name, want, got);
	endtask

	task automatic match_packet(input string name, input dispatch_packet_t pkt);
		expect_t     want;
		logic [31:0] want_addr;
		logic        want_illegal;
		seen_count++;
		held++;
		if (expected_q.size() == 0) begin
			// wrong path packets are fine while draining
			if (!drain_ok) begin
				errors++;
				$display("error at %0t: %s carries pc %h but no packet is expected",
				         $time, name, pkt.pc);
			end
		end else begin
			want = expected_q.pop_front();
			want_addr    = {want.pc[31:3], 3'b000};
			want_illegal = (want.op_class == 4'(ILLEGAL));
			if (fetch_addr != want_addr)
				report_value("imem_addr", want_addr, fetch_addr);
			if (pkt.pc != want.pc)
				report_value({name, ".pc"}, want.pc, pkt.pc);
			if (pkt.inst != mem[want.pc[9:2]])
				report_value({name, ".inst"}, mem[want.pc[9:2]], pkt.inst);
			if (4'(pkt.opcode_class) != want.op_class)
				report_value({name, ".opcode_class"}, 32'(want.op_class), 32'(pkt.opcode_class));
			if (pkt.illegal != want_illegal)
				report_value({name, ".illegal"}, 32'(want_illegal), 32'(pkt.illegal));
			if (pkt.dest_reg != want.dest)
				report_value({name, ".dest_reg"}, 32'(want.dest), 32'(pkt.dest_reg));
			if (pkt.src1_reg != want.rs1)
				report_value({name, ".src1_reg"}, 32'(want.rs1), 32'(pkt.src1_reg));
			if (pkt.src2_reg != want.rs2)
				report_value({name, ".src2_reg"}, 32'(want.rs2), 32'(pkt.src2_reg));
		end
	endtask

	// sample outputs at the falling edge and then drive memory and credit inputs
	task automatic step();
		int ret;
		@(negedge clock);
		if (dispatch_1.valid && !dispatch_0.valid) begin
			errors++;
			$display("error at %0t: dispatch_1 is valid while dispatch_0 is not", $time);
		end
		if (dispatch_0.valid && dispatch_1.valid && dispatch_1.pc != dispatch_0.pc + 32'd4)
			report_value("dispatch_1.pc", dispatch_0.pc + 32'd4, dispatch_1.pc);
		if (dispatch_0.valid)
			match_packet("dispatch_0", dispatch_0);
		if (dispatch_1.valid)
			match_packet("dispatch_1", dispatch_1);
		fetch_addr = imem_addr;
		if (held > `FE_CREDIT_MAX) begin
			errors++;
			$display("error at %0t: downstream holds %0d packets, over the credit limit",
			         $time, held);
		end
		quiet = (dispatch_0.valid || dispatch_1.valid) ? 0 : quiet + 1;
		rnd_state = lcg_next(rnd_state);
		imem_valid = (rnd_state[31:29] != 3'd0);
		if (hold_left > 0) begin
			hold_left--;
			ret = 0;
		end else if (rnd_state[27:24] == 4'd0) begin
			// downstream stalls for a stretch
			hold_left = 10;
			ret = 0;
		end else begin
			ret = int'(rnd_state[21:20]) % 3;
		end
		if (ret > held)
			ret = held;
		held -= ret;
		credit_return = 2'(ret);
	endtask

	//////////////////////////////
	// trace actions
	//////////////////////////////

	task automatic write_cfg(input logic [1:0] reg_addr, input logic [31:0] data);
		cfg_write = 1'b1;
		cfg_addr  = reg_addr;
		cfg_wdata = data;
		step();
		cfg_write = 1'b0;
	endtask

	task automatic wait_drained(input string what);
		int tries;
		tries = 0;
		while (expected_q.size() != 0 && tries < WAIT_LIMIT) begin
			step();
			tries++;
		end
		if (expected_q.size() != 0) begin
			errors++;
			stop_run = 1'b1;
			$display("timeout at %0t: %0d expected packets never arrived before the %s",
			         $time, expected_q.size(), what);
		end
	endtask

	task automatic apply_redirect(input logic [31:0] target);
		drain_ok = 1'b1;
		wait_drained("redirect");
		if (!stop_run) begin
			redirect.valid  = 1'b1;
			redirect.target = target;
			drain_ok = 1'b0;
			step();
			redirect.valid = 1'b0;
		end
	endtask

	task automatic finish_trace();
		int tries;
		drain_ok = 1'b1;
		wait_drained("end of the trace");
		if (!stop_run) begin
			write_cfg(`FE_CFG_CTRL, 32'd0);
			tries = 0;
			while ((held != 0 || quiet < 2) && tries < WAIT_LIMIT) begin
				step();
				tries++;
			end
			if (held != 0 || quiet < 2) begin
				errors++;
				$display("timeout at %0t: the front end did not go idle after disable", $time);
			end else begin
				cfg_addr = `FE_CFG_COUNT;
				step();
				if (cfg_rdata != 32'(seen_count))
					report_value("cfg_rdata", 32'(seen_count), cfg_rdata);
			end
		end
	endtask

	task automatic end_run();
		$display("errors %0d, packets seen %0d, expected packets left %0d",
		         errors, seen_count, expected_q.size());
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	//////////////////////////////
	// main flow
	//////////////////////////////

	initial begin
		reset         = 1'b1;
		imem_valid    = 1'b0;
		redirect      = '0;
		credit_return = 2'd0;
		cfg_write     = 1'b0;
		cfg_addr      = 2'd0;
		cfg_wdata     = '0;
		rnd_state     = 32'hbc8d6af3;
		fetch_addr    = '0;
		errors        = 0;
		seen_count    = 0;
		held          = 0;
		hold_left     = 0;
		quiet         = 0;
		drain_ok      = 1'b0;
		stop_run      = 1'b0;
		done          = 1'b0;
		// unloaded words decode as illegal and differ per address
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = {16'h5a5a, 8'(i), 8'h00};
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		fd = $fopen("testbench/frontend_trace.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the trace file");
		end else begin
			while (!done && !stop_run) begin
				code = $fscanf(fd, " %c", kind);
				if (code != 1) begin
					errors++;
					$display("the trace file ended without a D line");
					done = 1'b1;
				end else begin
					case (kind)
						"#": code = $fgets(line_buf, fd);
						"M": begin
							code = $fscanf(fd, "%h %h", addr, word);
							mem[addr[9:2]] = word;
						end
						"C": begin
							code = $fscanf(fd, "%h %h", addr, word);
							write_cfg(addr[1:0], word);
						end
						"R": begin
							code = $fscanf(fd, "%h", addr);
							apply_redirect(addr);
						end
						"E": begin
							code = $fscanf(fd, "%h %d %d %d %d", addr, cls, dst, s1, s2);
							entry.pc       = addr;
							entry.op_class = 4'(cls);
							entry.dest     = 5'(dst);
							entry.rs1      = 5'(s1);
							entry.rs2      = 5'(s2);
							expected_q.push_back(entry);
						end
						"D": begin
							finish_trace();
							done = 1'b1;
						end
						default: begin
							errors++;
							$display("unknown line type %c in the trace file", kind);
							done = 1'b1;
						end
					endcase
				end
			end
			$fclose(fd);
		end
		end_run();
	end

endmodule

// ==== flist.f ====
+incdir+include
verilog/frontend_pkg.sv
verilog/inst_decoder.sv
verilog/fetch_dispatch.sv
verilog/frontend_csr.sv
verilog/frontend_top.sv
testbench/frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the front end testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
mkdir -p build &&
verilator --binary --timing --top-module frontend_tb -f flist.f --Mdir build -o frontend_sim &&
./build/frontend_sim > build/sim.log 2>&1 || { echo "build or simulation did not complete"; exit 1; }
cat build/sim.log
grep -q "RESULT: FAIL" build/sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"

// ==== testbench/frontend_trace.txt ====
# M byte_addr word | C reg_addr data | R target | E pc class dest rs1 rs2 | D
# class: OP=0 OP_IMM=1 LOAD=2 STORE=3 BRANCH=4 JAL=5 JALR=6 LUI=7 AUIPC=8 SYSTEM=9 ILLEGAL=10
M 104 00500093
M 108 002081b3
M 10c 40118233
M 110 00812283
M 114 00512623
M 118 00208863
M 11c 00008000
M 120 008000ef
M 200 00008067
M 204 12345337
M 208 00001397
M 20c 00000073
M 210 00734433
M 214 40345493
C 0 00000104
C 1 00000001
E 104 1 1 0 0
E 108 0 3 1 2
E 10c 0 4 3 1
E 110 2 5 2 0
E 114 3 0 2 5
E 118 4 0 1 2
E 11c 10 0 1 0
E 120 5 1 0 0
R 200
E 200 6 0 1 0
E 204 7 6 0 0
E 208 8 7 0 0
E 20c 9 0 0 0
E 210 0 8 6 7
E 214 1 9 8 0
R 10c
E 10c 0 4 3 1
E 110 2 5 2 0
E 114 3 0 2 5
E 118 4 0 1 2
D
